// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = l2_cache_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/l2_cache_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_properties (
	input wire logic                          clk,
	input wire logic                          arst_n,
	input wire logic                          mem_read,
	input wire logic                          mem_write,
	input wire logic                          mem_resp,
	input wire logic                          pmem_read,
	input wire logic                          pmem_write,
	input wire logic                          pmem_resp,
	input wire logic [l2_pkg::addr_width-1:0] pmem_address
);

	pmem_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	// Address held while waiting; a write-back may move it in its response cycle.
	pmem_read_stable: assert property (@(posedge clk) disable iff (!arst_n)
		pmem_read && !pmem_resp |=> $stable(pmem_address))
		else $error("pmem_address changed during a pending read");

	pmem_write_stable: assert property (@(posedge clk) disable iff (!arst_n)
		pmem_write && !pmem_resp |=> pmem_resp || $stable(pmem_address))
		else $error("pmem_address changed during a pending write");

	resp_needs_request: assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |-> mem_read || mem_write)
		else $error("mem_resp without a request");

	resp_low_after_reset: assert property (@(posedge clk) !arst_n |=> !mem_resp)
		else $error("mem_resp high right after reset");

endmodule : l2_cache_properties

bind l2_cache l2_cache_properties u_properties (
	.clk          (clk),
	.arst_n       (arst_n),
	.mem_read     (mem_read),
	.mem_write    (mem_write),
	.mem_resp     (mem_resp),
	.pmem_read    (pmem_read),
	.pmem_write   (pmem_write),
	.pmem_resp    (pmem_resp),
	.pmem_address (pmem_address)
);

`default_nettype wire

// ==== bench/l2_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;

	localparam int mem_latency = 3;
	localparam int num_ops = 14;
	localparam int num_random = 40;
	localparam int timeout_ns = (num_ops + num_random) * 40 * 8 + 16 * 8;

	// Two sets, three colliding tags in set 2.
	localparam logic [31:0] addr_a = 32'h0000_1040;
	localparam logic [31:0] addr_b = 32'h0000_2040;
	localparam logic [31:0] addr_c = 32'h0000_3040;
	localparam logic [31:0] addr_d = 32'h0000_40a0;
	localparam l2_pkg::line_t line_w1 = {8{32'h1111_a001}};
	localparam l2_pkg::line_t line_w2 = {8{32'h2222_b002}};
	localparam l2_pkg::line_t line_w3 = {8{32'h3333_c003}};
	localparam l2_pkg::line_t line_w4 = {8{32'h4444_d004}};

	typedef struct {
		logic          write;
		logic [31:0]   addr;
		l2_pkg::line_t wdata;
		int            reads;
		int            writes;
		int            cycles;
	} op_t;

	logic                          clk = 1'b0;
	logic                          arst_n;
	logic [l2_pkg::addr_width-1:0] mem_address;
	logic                          mem_read;
	logic                          mem_write;
	l2_pkg::line_t                 mem_wdata;
	logic                          mem_resp;
	l2_pkg::line_t                 mem_rdata;
	logic [l2_pkg::addr_width-1:0] pmem_address;
	logic                          pmem_read;
	logic                          pmem_write;
	l2_pkg::line_t                 pmem_wdata;
	logic                          pmem_resp;
	l2_pkg::line_t                 pmem_rdata;

	op_t           ops [num_ops];
	l2_pkg::line_t phys [logic [31:0]];   // Backing store.
	l2_pkg::line_t shadow [logic [31:0]]; // Latest client view of each line.
	l2_pkg::tag_t  m_tag [l2_pkg::num_sets][l2_pkg::num_ways];
	logic          m_valid [l2_pkg::num_sets][l2_pkg::num_ways];
	logic          m_dirty [l2_pkg::num_sets][l2_pkg::num_ways];
	logic          m_lru [l2_pkg::num_sets];
	int            read_count;
	int            write_count;
	int            reads_at_wb;
	logic [31:0]   wb_addr;
	l2_pkg::line_t wb_data;
	int            errors;
	int            checks;
	integer        seed;

	always #4 clk = ~clk;

	l2_cache u_l2_cache (
		.clk          (clk),
		.arst_n       (arst_n),
		.mem_address  (mem_address),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_wdata    (mem_wdata),
		.mem_resp     (mem_resp),
		.mem_rdata    (mem_rdata),
		.pmem_address (pmem_address),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_wdata   (pmem_wdata),
		.pmem_resp    (pmem_resp),
		.pmem_rdata   (pmem_rdata)
	);

	function automatic l2_pkg::line_t pattern_line(logic [31:0] line_addr);
		l2_pkg::line_t line;
		for (int w = 0; w < 8; w++) begin
			line[w*32 +: 32] = (line_addr | (w << 2)) ^ 32'h5ca1_ab1e; // Word address based.
		end
		return line;
	endfunction

	function automatic l2_pkg::line_t client_line(logic [31:0] line_addr);
		if (shadow.exists(line_addr)) begin
			return shadow[line_addr];
		end
		return pattern_line(line_addr);
	endfunction

	task automatic value_error(input int n, input string what, input logic [255:0] got,
		input logic [255:0] exp);
		$display("FAILED op %0d %s: got %0h expected %0h", n, what, got, exp);
		errors++;
	endtask

	// Shadow model of tags, valid, dirty and LRU; updates state and predicts the op.
	task automatic predict(input logic write, input logic [31:0] line_addr,
		input l2_pkg::line_t wdata, output l2_pkg::line_t exp_data, output int exp_reads,
		output int exp_writes, output int exp_cycles, output logic [31:0] exp_wb_addr,
		output l2_pkg::line_t exp_wb_data);
		l2_pkg::index_t idx;
		l2_pkg::tag_t   tag;
		int             way;
		int             victim;
		idx = line_addr[l2_pkg::offset_width +: l2_pkg::index_width];
		tag = line_addr[l2_pkg::addr_width-1 -: l2_pkg::tag_width];
		way = -1;
		exp_reads = 0;
		exp_writes = 0;
		exp_wb_addr = '0;
		exp_wb_data = '0;
		for (int w = 0; w < l2_pkg::num_ways; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
				way = w;
			end
		end
		if (way >= 0) begin
			exp_cycles = 2;
			if (write) begin
				m_dirty[idx][way] = 1'b1;
			end
			m_lru[idx] = (way == 0);
		end else begin
			victim = m_lru[idx] ? 1 : 0;
			exp_cycles = write ? 3 : mem_latency + 1;
			if (m_valid[idx][victim] && m_dirty[idx][victim]) begin
				exp_writes = 1;
				exp_wb_addr = {m_tag[idx][victim], idx, {l2_pkg::offset_width{1'b0}}};
				exp_wb_data = client_line(exp_wb_addr);
				exp_cycles = 2 + mem_latency + (write ? 1 : mem_latency);
			end
			exp_reads = write ? 0 : 1;
			m_tag[idx][victim] = tag;
			m_valid[idx][victim] = 1'b1;
			m_dirty[idx][victim] = write;
			m_lru[idx] = (victim == 0);
		end
		if (write) begin
			shadow[line_addr] = wdata;
		end
		exp_data = client_line(line_addr);
	endtask

	// Negative expected counts take the model's prediction.
	task automatic apply_op(input int n, input logic write, input logic [31:0] addr,
		input l2_pkg::line_t wdata, input int want_reads, input int want_writes,
		input int want_cycles);
		logic [31:0]   line_addr;
		l2_pkg::line_t exp_data;
		l2_pkg::line_t got_data;
		l2_pkg::line_t exp_wb_data;
		logic [31:0]   exp_wb_addr;
		int            exp_reads;
		int            exp_writes;
		int            exp_cycles;
		int            start_reads;
		int            start_writes;
		int            cycles;
		int            errors_before;
		logic          done;
		string         result;
		line_addr = {addr[31:5], 5'h0};
		predict(write, line_addr, wdata, exp_data, exp_reads, exp_writes, exp_cycles,
			exp_wb_addr, exp_wb_data);
		if (want_reads >= 0) begin
			exp_reads = want_reads;
			exp_writes = want_writes;
			exp_cycles = want_cycles;
		end
		errors_before = errors;
		start_reads = read_count;
		start_writes = write_count;
		@(posedge clk);
		#1;
		mem_address = addr;
		mem_read = !write;
		mem_write = write;
		mem_wdata = wdata;
		cycles = 0;
		done = 1'b0;
		got_data = '0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (mem_resp) begin
				done = 1'b1;
				got_data = mem_rdata;
			end
		end
		@(posedge clk);
		#1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		checks += 4;
		if (!write && got_data !== exp_data) begin
			value_error(n, "mem_rdata", got_data, exp_data);
		end
		if (read_count - start_reads != exp_reads) begin
			value_error(n, "pmem_read count", 256'(read_count - start_reads), 256'(exp_reads));
		end
		if (write_count - start_writes != exp_writes) begin
			value_error(n, "pmem_write count", 256'(write_count - start_writes),
				256'(exp_writes));
		end
		if (cycles != exp_cycles) begin
			value_error(n, "mem_resp cycle", 256'(cycles), 256'(exp_cycles));
		end
		if (exp_writes == 1) begin
			checks += 3;
			if (wb_addr !== exp_wb_addr) begin
				value_error(n, "pmem_address", 256'(wb_addr), 256'(exp_wb_addr));
			end
			if (wb_data !== exp_wb_data) begin
				value_error(n, "pmem_wdata", wb_data, exp_wb_data);
			end
			if (reads_at_wb != start_reads) begin
				$display("op %0d: a physical read came before the write-back", n);
				errors++;
			end
		end
		if (errors == errors_before) begin
			result = "ok";
		end else begin
			result = "mismatch";
		end
		$display("op %0d write=%0d addr %h, %0d cycles: %s", n, write, addr, cycles, result);
	endtask

	// Physical memory, answering in the third cycle of each request.
	initial begin : memory_model
		int            wait_cycles;
		logic          respond;
		logic          cap_write;
		logic [31:0]   cap_addr;
		l2_pkg::line_t cap_wdata;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		read_count = 0;
		write_count = 0;
		reads_at_wb = 0;
		wb_addr = '0;
		wb_data = '0;
		wait_cycles = 0;
		cap_write = 1'b0;
		cap_addr = '0;
		cap_wdata = '0;
		forever begin
			@(negedge clk);
			respond = 1'b0;
			if (pmem_resp || !(pmem_read || pmem_write)) begin
				wait_cycles = 0;
			end else begin
				wait_cycles++;
				if (wait_cycles == mem_latency - 1) begin
					respond = 1'b1;
					cap_write = pmem_write; // Address moves off the victim in the response cycle.
					cap_addr = pmem_address;
					cap_wdata = pmem_wdata;
				end
			end
			@(posedge clk);
			#1;
			pmem_resp = respond;
			if (respond && cap_write) begin
				phys[cap_addr] = cap_wdata;
				wb_addr = cap_addr;
				wb_data = cap_wdata;
				reads_at_wb = read_count;
				write_count++;
			end else if (respond) begin
				pmem_rdata = phys.exists(cap_addr) ? phys[cap_addr] : pattern_line(cap_addr);
				read_count++;
			end
		end
	end

	initial begin : watchdog
		#(timeout_ns);
		$display("Timeout: the operations did not finish in the expected time");
		$display("TB FAILED");
		$finish;
	end

	initial begin : stimulus
		logic          write;
		logic [31:0]   addr;
		logic [31:0]   r;
		logic [31:0]   r2;
		l2_pkg::line_t wdata;
		seed = 32;
		errors = 0;
		checks = 0;
		arst_n = 1'b0;
		mem_address = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_wdata = '0;
		for (int s = 0; s < l2_pkg::num_sets; s++) begin
			m_lru[s] = 1'b0;
			for (int w = 0; w < l2_pkg::num_ways; w++) begin
				m_tag[s][w] = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
			end
		end
		// Operation, address, write data, physical reads, physical writes, cycles.
		ops[0] = '{1'b0, addr_a, '0, 1, 0, 4};
		ops[1] = '{1'b0, addr_a, '0, 0, 0, 2};
		ops[2] = '{1'b1, addr_a, line_w1, 0, 0, 2};
		ops[3] = '{1'b0, addr_a, '0, 0, 0, 2};
		ops[4] = '{1'b1, addr_d, line_w2, 0, 0, 3}; // Write miss, clean victim.
		ops[5] = '{1'b0, addr_d, '0, 0, 0, 2};
		ops[6] = '{1'b0, addr_b, '0, 1, 0, 4};
		ops[7] = '{1'b0, addr_c, '0, 1, 1, 8}; // Evicts dirty A.
		ops[8] = '{1'b0, addr_a, '0, 1, 0, 4};
		ops[9] = '{1'b1, addr_b, line_w3, 0, 0, 3};
		ops[10] = '{1'b1, addr_c, line_w4, 0, 0, 3};
		ops[11] = '{1'b0, addr_a, '0, 1, 1, 8};
		ops[12] = '{1'b0, addr_b, '0, 1, 1, 8};
		ops[13] = '{1'b0, addr_c, '0, 1, 0, 4};
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		checks++;
		if (mem_resp !== 1'b0 || pmem_read !== 1'b0 || pmem_write !== 1'b0) begin
			$display("Outputs were not idle after reset");
			errors++;
		end
		for (int i = 0; i < num_ops; i++) begin
			apply_op(i, ops[i].write, ops[i].addr, ops[i].wdata, ops[i].reads,
				ops[i].writes, ops[i].cycles);
		end
		for (int i = 0; i < num_random; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			write = r[3];
			addr = {16'h0, 2'b00, r[1:0], 4'h0, r[2] ? 3'd5 : 3'd2, 5'h0};
			for (int w = 0; w < 8; w++) begin
				wdata[w*32 +: 32] = r2 ^ (w * 32'h0101_0101);
			end
			apply_op(num_ops + i, write, addr, wdata, -1, -1, -1);
		end
		$display("%0d ops, %0d checks, %0d errors", num_ops + num_random, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule : l2_cache_tb

`default_nettype wire

// ==== sim.f ====
src/l2_pkg.sv
src/l2_array.sv
src/l2_way.sv
src/l2_way_select.sv
src/l2_cache_control.sv
src/l2_cache.sv
bench/l2_cache_properties.sv
bench/l2_cache_tb.sv

// ==== src/l2_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_array #(
	parameter type payload_t = l2_pkg::line_t,
	parameter int depth = l2_pkg::num_sets
) (
	input  wire logic           clk,
	input  wire logic           read,
	input  wire logic           write,
	input  wire l2_pkg::index_t index,
	input  wire payload_t       wdata,
	output      payload_t       rdata
);

	payload_t mem [depth];

	always_ff @(posedge clk) begin
		if (write) begin
			mem[index] <= wdata;
		end
	end

	// Registered read; a write shows its own value on the next cycle.
	always_ff @(posedge clk) begin
		if (write) begin
			rdata <= wdata;
		end else if (read) begin
			rdata <= mem[index];
		end
	end

endmodule : l2_array

`default_nettype wire

// ==== src/l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache (
	input  wire logic                          clk,
	input  wire logic                          arst_n,
	input  wire logic [l2_pkg::addr_width-1:0] mem_address,
	input  wire logic                          mem_read,
	input  wire logic                          mem_write,
	input  wire l2_pkg::line_t                 mem_wdata,
	output      logic                          mem_resp,
	output      l2_pkg::line_t                 mem_rdata,
	output      logic [l2_pkg::addr_width-1:0] pmem_address,
	output      logic                          pmem_read,
	output      logic                          pmem_write,
	output      l2_pkg::line_t                 pmem_wdata,
	input  wire logic                          pmem_resp,
	input  wire l2_pkg::line_t                 pmem_rdata
);

	logic [l2_pkg::num_ways-1:0]        load_data;
	logic [l2_pkg::num_ways-1:0]        load_tag;
	logic [l2_pkg::num_ways-1:0]        set_valid;
	logic [l2_pkg::num_ways-1:0]        set_dirty;
	logic [l2_pkg::num_ways-1:0]        clear_dirty;
	logic                               read_data;
	logic                               fill_from_pmem;
	logic                               load_lru;
	logic                               hit;
	logic                               tag0_hit;
	logic                               tag1_hit;
	logic                               dirty_ctrl;
	logic                               lru_out;
	logic [l2_pkg::num_ways-1:0]        way_hit;
	logic [l2_pkg::num_ways-1:0]        way_dirty;
	l2_pkg::line_t [l2_pkg::num_ways-1:0] way_line;
	l2_pkg::tag_t [l2_pkg::num_ways-1:0]  way_tag;

	l2_cache_control u_control (
		.clk            (clk),
		.arst_n         (arst_n),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.pmem_resp      (pmem_resp),
		.hit            (hit),
		.dirty_ctrl     (dirty_ctrl),
		.lru_out        (lru_out),
		.tag1_hit       (tag1_hit),
		.tag0_hit       (tag0_hit),
		.pmem_read      (pmem_read),
		.pmem_write     (pmem_write),
		.mem_resp       (mem_resp),
		.set_dirty      (set_dirty),
		.clear_dirty    (clear_dirty),
		.load_data      (load_data),
		.load_tag       (load_tag),
		.set_valid      (set_valid),
		.load_lru       (load_lru),
		.read_data      (read_data),
		.fill_from_pmem (fill_from_pmem)
	);

	for (genvar i = 0; i < l2_pkg::num_ways; i++) begin : gen_way
		l2_way u_way (
			.clk            (clk),
			.arst_n         (arst_n),
			.read_data      (read_data),
			.load_data      (load_data[i]),
			.load_tag       (load_tag[i]),
			.set_valid      (set_valid[i]),
			.set_dirty      (set_dirty[i]),
			.clear_dirty    (clear_dirty[i]),
			.fill_from_pmem (fill_from_pmem),
			.index          (mem_address[l2_pkg::offset_width +: l2_pkg::index_width]),
			.tag            (mem_address[l2_pkg::addr_width-1 -: l2_pkg::tag_width]),
			.mem_wdata      (mem_wdata),
			.pmem_rdata     (pmem_rdata),
			.way_hit        (way_hit[i]),
			.way_dirty      (way_dirty[i]),
			.way_line       (way_line[i]),
			.way_tag        (way_tag[i])
		);
	end

	l2_way_select u_way_select (
		.clk          (clk),
		.arst_n       (arst_n),
		.load_lru     (load_lru),
		.pmem_write   (pmem_write),
		.mem_address  (mem_address),
		.way_hit      (way_hit),
		.way_dirty    (way_dirty),
		.way_line     (way_line),
		.way_tag      (way_tag),
		.pmem_rdata   (pmem_rdata),
		.hit          (hit),
		.tag0_hit     (tag0_hit),
		.tag1_hit     (tag1_hit),
		.dirty_ctrl   (dirty_ctrl),
		.lru_out      (lru_out),
		.mem_rdata    (mem_rdata),
		.pmem_wdata   (pmem_wdata),
		.pmem_address (pmem_address)
	);

endmodule : l2_cache

`default_nettype wire

// ==== src/l2_cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control (
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire logic       mem_read,
	input  wire logic       mem_write,
	input  wire logic       pmem_resp,
	input  wire logic       hit,
	input  wire logic       dirty_ctrl,
	input  wire logic       lru_out,
	input  wire logic       tag1_hit,
	input  wire logic       tag0_hit,
	output      logic       pmem_read,
	output      logic       pmem_write,
	output      logic       mem_resp,
	output      logic [1:0] set_dirty,
	output      logic [1:0] clear_dirty,
	output      logic [1:0] load_data,
	output      logic [1:0] load_tag,
	output      logic [1:0] set_valid,
	output      logic       load_lru,
	output      logic       read_data,
	output      logic       fill_from_pmem
);

	typedef enum logic [2:0] {
		idle,
		hit_detection,
		go_update,
		load,
		plop,
		store
	} state_t;

	state_t     state;
	state_t     next_state;
	logic [1:0] victim;
	logic [1:0] hit_way;

	assign victim = {lru_out, ~lru_out};
	assign hit_way = {tag1_hit, tag0_hit};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		unique case (state)
			idle: if (mem_read || mem_write) begin
				next_state = hit_detection;
			end
			hit_detection: begin
				if (hit) begin
					next_state = go_update;
				end else if (dirty_ctrl) begin
					next_state = store; // Write back first.
				end else begin
					next_state = mem_read ? load : plop;
				end
			end
			go_update: next_state = idle; // Client drops its request here.
			load: if (pmem_resp) begin
				next_state = go_update;
			end
			plop: next_state = go_update;
			store: if (pmem_resp) begin
				next_state = mem_read ? load : plop;
			end
			default: next_state = idle;
		endcase
	end

	always_comb begin
		load_lru = 1'b0;
		read_data = 1'b0;
		load_data = 2'b00;
		load_tag = 2'b00;
		set_valid = 2'b00;
		set_dirty = 2'b00;
		clear_dirty = 2'b00;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		unique case (state)
			idle: read_data = mem_read | mem_write;
			hit_detection: begin
				if (hit) begin
					load_lru = 1'b1;
					mem_resp = 1'b1;
					if (mem_write) begin
						load_data = hit_way;
						set_dirty = hit_way;
					end
				end else if (!dirty_ctrl && mem_read) begin
					pmem_read = 1'b1; // Start the fetch early.
				end
			end
			load: begin
				if (pmem_resp) begin
					load_data = victim;
					load_tag = victim;
					set_valid = victim;
					load_lru = 1'b1;
					mem_resp = 1'b1;
				end else begin
					pmem_read = 1'b1;
				end
			end
			plop: begin
				// Write miss installs the client line directly.
				load_data = victim;
				load_tag = victim;
				set_valid = victim;
				set_dirty = victim;
				load_lru = 1'b1;
				mem_resp = 1'b1;
			end
			store: begin
				if (pmem_resp) begin
					pmem_read = mem_read;
				end else begin
					pmem_write = 1'b1;
					clear_dirty = victim;
				end
			end
			default: ;
		endcase
	end

	assign fill_from_pmem = (state == load);

endmodule : l2_cache_control

`default_nettype wire

// ==== src/l2_pkg.sv ====
`default_nettype none

package l2_pkg;

	// Byte address geometry.
	localparam int addr_width = 32;
	localparam int line_bytes = 32;
	localparam int offset_width = $clog2(line_bytes);
	localparam int line_width = line_bytes * 8;

	// Set geometry.
	localparam int num_sets = 8;
	localparam int index_width = $clog2(num_sets);
	localparam int tag_width = addr_width - index_width - offset_width;

	// Two ways, matching the controller's per-way strobes.
	localparam int num_ways = 2;

	// A whole cache line.
	typedef logic [line_width-1:0] line_t;

	// Upper address bits kept per line.
	typedef logic [tag_width-1:0] tag_t;

	// Set selector.
	typedef logic [index_width-1:0] index_t;

endpackage : l2_pkg

`default_nettype wire

// ==== src/l2_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_way (
	input  wire logic           clk,
	input  wire logic           arst_n,
	input  wire logic           read_data,
	input  wire logic           load_data,
	input  wire logic           load_tag,
	input  wire logic           set_valid,
	input  wire logic           set_dirty,
	input  wire logic           clear_dirty,
	input  wire logic           fill_from_pmem,
	input  wire l2_pkg::index_t index,
	input  wire l2_pkg::tag_t   tag,
	input  wire l2_pkg::line_t  mem_wdata,
	input  wire l2_pkg::line_t  pmem_rdata,
	output      logic           way_hit,
	output      logic           way_dirty,
	output      l2_pkg::line_t  way_line,
	output      l2_pkg::tag_t   way_tag
);

	logic [l2_pkg::num_sets-1:0] valid;
	logic [l2_pkg::num_sets-1:0] dirty;
	l2_pkg::line_t               line_wdata;

	assign line_wdata = fill_from_pmem ? pmem_rdata : mem_wdata; // Fill or client write.

	l2_array #(
		.payload_t (l2_pkg::tag_t),
		.depth     (l2_pkg::num_sets)
	) u_tag_array (
		.clk   (clk),
		.read  (read_data),
		.write (load_tag),
		.index (index),
		.wdata (tag),
		.rdata (way_tag)
	);

	l2_array #(
		.payload_t (l2_pkg::line_t),
		.depth     (l2_pkg::num_sets)
	) u_data_array (
		.clk   (clk),
		.read  (read_data),
		.write (load_data),
		.index (index),
		.wdata (line_wdata),
		.rdata (way_line)
	);

	// Per-set state bits.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
			dirty <= '0;
		end else begin
			if (set_valid) begin
				valid[index] <= 1'b1;
			end
			if (set_dirty) begin
				dirty[index] <= 1'b1;
			end else if (clear_dirty) begin
				dirty[index] <= 1'b0;
			end
		end
	end

	assign way_dirty = dirty[index];
	assign way_hit = valid[index] && (way_tag == tag); // Tag read in idle.

endmodule : l2_way

`default_nettype wire

// ==== src/l2_way_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_way_select (
	input  wire logic                                clk,
	input  wire logic                                arst_n,
	input  wire logic                                load_lru,
	input  wire logic                                pmem_write,
	input  wire logic [l2_pkg::addr_width-1:0]       mem_address,
	input  wire logic [l2_pkg::num_ways-1:0]         way_hit,
	input  wire logic [l2_pkg::num_ways-1:0]         way_dirty,
	input  wire l2_pkg::line_t [l2_pkg::num_ways-1:0] way_line,
	input  wire l2_pkg::tag_t [l2_pkg::num_ways-1:0]  way_tag,
	input  wire l2_pkg::line_t                       pmem_rdata,
	output      logic                                hit,
	output      logic                                tag0_hit,
	output      logic                                tag1_hit,
	output      logic                                dirty_ctrl,
	output      logic                                lru_out,
	output      l2_pkg::line_t                       mem_rdata,
	output      l2_pkg::line_t                       pmem_wdata,
	output      logic [l2_pkg::addr_width-1:0]       pmem_address
);

	logic [l2_pkg::num_sets-1:0] lru;
	l2_pkg::index_t              index;
	l2_pkg::line_t               hit_line;

	assign index = mem_address[l2_pkg::offset_width +: l2_pkg::index_width];

	assign hit = |way_hit;
	assign tag0_hit = way_hit[0];
	assign tag1_hit = way_hit[1];

	// LRU way of the current set is the victim.
	assign lru_out = lru[index];
	assign dirty_ctrl = way_dirty[lru_out];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lru <= '0;
		end else if (load_lru) begin
			if (hit) begin
				lru[index] <= way_hit[0]; // Point at the way that missed.
			end else begin
				lru[index] <= ~lru[index]; // Filled way becomes most recent.
			end
		end
	end

	always_comb begin
		hit_line = '0;
		for (int w = 0; w < l2_pkg::num_ways; w++) begin
			if (way_hit[w]) begin
				hit_line = way_line[w];
			end
		end
	end

	assign mem_rdata = hit ? hit_line : pmem_rdata; // Miss data passes straight through.

	assign pmem_wdata = way_line[lru_out];

	// Victim address during write-back, request line otherwise.
	always_comb begin
		if (pmem_write) begin
			pmem_address = {way_tag[lru_out], index, {l2_pkg::offset_width{1'b0}}};
		end else begin
			pmem_address = {mem_address[l2_pkg::addr_width-1:l2_pkg::offset_width],
				{l2_pkg::offset_width{1'b0}}};
		end
	end

endmodule : l2_way_select

`default_nettype wire
